/* rtl/rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// instructions per dispatch and retire group
`define ROB_WIDTH 2

// power of two and a multiple of ROB_WIDTH
`define ROB_ENTRIES 16

`define AREG_NUM 8

`define DATA_W 32
`define PC_W 16

`endif

/* rtl/rob_pkg.sv */
`include "rob_defs.svh"

package rob_pkg;

	// entry index
	typedef logic [$clog2(`ROB_ENTRIES)-1:0] tag_t;

	// entry index with wrap bit on top
	typedef logic [$clog2(`ROB_ENTRIES):0] rob_ptr_t;

	typedef logic [$clog2(`AREG_NUM)-1:0] areg_t;

	typedef logic [`DATA_W-1:0] data_t;

	typedef logic [`PC_W-1:0] pc_t;

	// written at dispatch
	typedef struct packed {
		areg_t dst;
		pc_t pc;
	} alloc_entry_t;

	// written at writeback
	typedef struct packed {
		data_t data;
	} result_entry_t;

endpackage

/* rtl/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
	parameter type entry_t = logic,
	parameter int DEPTH = 8,
	parameter int RPORTS = 1
) (
	input logic clk,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] waddr,
	input entry_t wdata,
	input logic [$clog2(DEPTH)-1:0] raddr [RPORTS],
	output entry_t rdata [RPORTS]
);

	entry_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read ports see the old word during a write
	always_comb begin
		for (int i = 0; i < RPORTS; i++) begin
			rdata[i] = mem[raddr[i]];
		end
	end

endmodule

/* rtl/rename_stage.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rename_stage (
	input logic clk,
	input logic reset,
	input logic [`ROB_WIDTH-1:0] disp_valid,
	input rob_pkg::areg_t disp_dst [`ROB_WIDTH],
	input rob_pkg::areg_t disp_src [`ROB_WIDTH],
	input rob_pkg::pc_t disp_pc [`ROB_WIDTH],
	output rob_pkg::tag_t src_tag [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] src_pending,
	output rob_pkg::data_t src_data [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] alloc_valid,
	output rob_pkg::areg_t alloc_dst [`ROB_WIDTH],
	output rob_pkg::pc_t alloc_pc [`ROB_WIDTH],
	input rob_pkg::tag_t alloc_tag [`ROB_WIDTH],
	input logic stall,
	output rob_pkg::tag_t look_tag [`ROB_WIDTH],
	input logic [`ROB_WIDTH-1:0] look_done,
	input rob_pkg::data_t look_data [`ROB_WIDTH],
	output rob_pkg::areg_t arch_raddr [`ROB_WIDTH],
	input rob_pkg::data_t arch_rdata [`ROB_WIDTH],
	input logic [`ROB_WIDTH-1:0] clr_valid,
	input rob_pkg::tag_t clr_tag [`ROB_WIDTH]
);

	// alias table from areg to latest in-flight producer
	logic [`AREG_NUM-1:0] map_valid;
	rob_pkg::tag_t map_tag [`AREG_NUM];

	assign alloc_valid = disp_valid;
	assign alloc_dst = disp_dst;
	assign alloc_pc = disp_pc;

	always_comb begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			look_tag[i] = map_tag[disp_src[i]];
			arch_raddr[i] = disp_src[i];
		end
	end

	always_comb begin
		logic fwd;
		rob_pkg::tag_t fwd_tag;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			fwd = 1'b0;
			fwd_tag = '0;
			// nearest earlier slot of the group wins
			for (int j = 0; j < i; j++) begin
				if (disp_valid[j] && disp_dst[j] == disp_src[i]) begin
					fwd = 1'b1;
					fwd_tag = alloc_tag[j];
				end
			end
			if (fwd) begin
				src_tag[i] = fwd_tag;
				src_pending[i] = 1'b1;
				src_data[i] = '0;
			end else if (map_valid[disp_src[i]]) begin
				src_tag[i] = map_tag[disp_src[i]];
				src_pending[i] = !look_done[i];
				src_data[i] = look_data[i];
			end else begin
				src_tag[i] = '0;
				src_pending[i] = 1'b0;
				src_data[i] = arch_rdata[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			map_valid <= '0;
		end else begin
			// drop only mappings still pointing at the retired tag
			for (int k = 0; k < `ROB_WIDTH; k++) begin
				for (int r = 0; r < `AREG_NUM; r++) begin
					if (clr_valid[k] && map_valid[r] && map_tag[r] == clr_tag[k]) begin
						map_valid[r] <= 1'b0;
					end
				end
			end
			// remap after the clear so a fresh mapping survives
			if (!stall) begin
				for (int i = 0; i < `ROB_WIDTH; i++) begin
					if (disp_valid[i]) begin
						map_valid[disp_dst[i]] <= 1'b1;
						map_tag[disp_dst[i]] <= alloc_tag[i];
					end
				end
			end
		end
	end

endmodule

/* rtl/rob.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob (
	input logic clk,
	input logic reset,
	input logic [`ROB_WIDTH-1:0] alloc_valid,
	input rob_pkg::areg_t alloc_dst [`ROB_WIDTH],
	input rob_pkg::pc_t alloc_pc [`ROB_WIDTH],
	output rob_pkg::tag_t alloc_tag [`ROB_WIDTH],
	output logic stall,
	input logic [`ROB_WIDTH-1:0] wb_valid,
	input rob_pkg::tag_t wb_tag [`ROB_WIDTH],
	input rob_pkg::data_t wb_data [`ROB_WIDTH],
	input rob_pkg::tag_t look_tag [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] look_done,
	output rob_pkg::data_t look_data [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] ret_valid,
	output rob_pkg::tag_t ret_tag [`ROB_WIDTH],
	output rob_pkg::areg_t ret_dst [`ROB_WIDTH],
	output rob_pkg::data_t ret_data [`ROB_WIDTH],
	output rob_pkg::pc_t ret_pc [`ROB_WIDTH]
);

	localparam int NBANK = `ROB_WIDTH;
	localparam int BANK_DEPTH = `ROB_ENTRIES / NBANK;
	localparam int OFF_W = $clog2(BANK_DEPTH);

	typedef logic [OFF_W-1:0] off_t;

	// consecutive tags land in different banks
	function automatic int bank_of(rob_pkg::tag_t t);
		return int'(t) % NBANK;
	endfunction

	function automatic off_t off_of(rob_pkg::tag_t t);
		return off_t'(int'(t) / NBANK);
	endfunction

	rob_pkg::rob_ptr_t head;
	rob_pkg::rob_ptr_t tail;
	rob_pkg::rob_ptr_t head_nxt;
	rob_pkg::rob_ptr_t tail_nxt;
	rob_pkg::rob_ptr_t used;
	logic [`ROB_ENTRIES-1:0] done;

	logic a_we [NBANK];
	off_t a_waddr [NBANK];
	rob_pkg::alloc_entry_t a_wdata [NBANK];
	off_t a_raddr [`ROB_WIDTH];
	rob_pkg::alloc_entry_t a_rdata [NBANK][`ROB_WIDTH];

	logic r_we [NBANK];
	off_t r_waddr [NBANK];
	rob_pkg::result_entry_t r_wdata [NBANK];
	// retire ports come before the source lookup ports
	off_t r_raddr [2*`ROB_WIDTH];
	rob_pkg::result_entry_t r_rdata [NBANK][2*`ROB_WIDTH];

	assign used = tail - head;
	assign stall = used > rob_pkg::rob_ptr_t'(`ROB_ENTRIES - `ROB_WIDTH);

	always_comb begin
		rob_pkg::rob_ptr_t p;
		p = tail;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			alloc_tag[i] = rob_pkg::tag_t'(p);
			if (alloc_valid[i]) begin
				p = p + rob_pkg::rob_ptr_t'(1);
			end
		end
		tail_nxt = stall ? tail : p;
	end

	// in-order retire with each slot chained on the one below
	always_comb begin
		rob_pkg::rob_ptr_t p;
		logic chain;
		chain = 1'b1;
		head_nxt = head;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			p = head + rob_pkg::rob_ptr_t'(i);
			ret_tag[i] = rob_pkg::tag_t'(p);
			chain = chain && (used > rob_pkg::rob_ptr_t'(i)) && done[rob_pkg::tag_t'(p)];
			ret_valid[i] = chain;
			if (chain) begin
				head_nxt = p + rob_pkg::rob_ptr_t'(1);
			end
		end
	end

	// two strobes of one cycle must target different banks
	always_comb begin
		for (int b = 0; b < NBANK; b++) begin
			a_we[b] = 1'b0;
			a_waddr[b] = '0;
			a_wdata[b] = '0;
			r_we[b] = 1'b0;
			r_waddr[b] = '0;
			r_wdata[b] = '0;
		end
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			if (!stall && alloc_valid[i]) begin
				a_we[bank_of(alloc_tag[i])] = 1'b1;
				a_waddr[bank_of(alloc_tag[i])] = off_of(alloc_tag[i]);
				a_wdata[bank_of(alloc_tag[i])].dst = alloc_dst[i];
				a_wdata[bank_of(alloc_tag[i])].pc = alloc_pc[i];
			end
			if (wb_valid[i]) begin
				r_we[bank_of(wb_tag[i])] = 1'b1;
				r_waddr[bank_of(wb_tag[i])] = off_of(wb_tag[i]);
				r_wdata[bank_of(wb_tag[i])].data = wb_data[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			a_raddr[i] = off_of(ret_tag[i]);
			r_raddr[i] = off_of(ret_tag[i]);
			r_raddr[`ROB_WIDTH + i] = off_of(look_tag[i]);
		end
	end

	for (genvar b = 0; b < NBANK; b++) begin : g_bank
		bank_ram #(
			.entry_t(rob_pkg::alloc_entry_t),
			.DEPTH(BANK_DEPTH),
			.RPORTS(`ROB_WIDTH)
		) i_alloc_ram (
			.clk,
			.we(a_we[b]),
			.waddr(a_waddr[b]),
			.wdata(a_wdata[b]),
			.raddr(a_raddr),
			.rdata(a_rdata[b])
		);

		bank_ram #(
			.entry_t(rob_pkg::result_entry_t),
			.DEPTH(BANK_DEPTH),
			.RPORTS(2 * `ROB_WIDTH)
		) i_result_ram (
			.clk,
			.we(r_we[b]),
			.waddr(r_waddr[b]),
			.wdata(r_wdata[b]),
			.raddr(r_raddr),
			.rdata(r_rdata[b])
		);
	end

	always_comb begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			ret_dst[i] = a_rdata[bank_of(ret_tag[i])][i].dst;
			ret_pc[i] = a_rdata[bank_of(ret_tag[i])][i].pc;
			ret_data[i] = r_rdata[bank_of(ret_tag[i])][i].data;
			look_done[i] = done[look_tag[i]];
			look_data[i] = r_rdata[bank_of(look_tag[i])][`ROB_WIDTH + i].data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			done <= '0;
		end else begin
			head <= head_nxt;
			tail <= tail_nxt;
			for (int i = 0; i < `ROB_WIDTH; i++) begin
				if (!stall && alloc_valid[i]) begin
					done[alloc_tag[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < `ROB_WIDTH; i++) begin
				if (wb_valid[i]) begin
					done[wb_tag[i]] <= 1'b1;
				end
			end
		end
	end

endmodule

/* rtl/retire_stage.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module retire_stage (
	input logic clk,
	input logic reset,
	input logic [`ROB_WIDTH-1:0] ret_valid,
	input rob_pkg::areg_t ret_dst [`ROB_WIDTH],
	input rob_pkg::data_t ret_data [`ROB_WIDTH],
	input rob_pkg::pc_t ret_pc [`ROB_WIDTH],
	input rob_pkg::tag_t ret_tag [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] out_valid,
	output rob_pkg::areg_t out_dst [`ROB_WIDTH],
	output rob_pkg::data_t out_data [`ROB_WIDTH],
	output rob_pkg::pc_t out_pc [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] clr_valid,
	output rob_pkg::tag_t clr_tag [`ROB_WIDTH],
	input rob_pkg::areg_t arch_raddr [`ROB_WIDTH],
	output rob_pkg::data_t arch_rdata [`ROB_WIDTH]
);

	// committed register file
	rob_pkg::data_t arch_rf [`AREG_NUM];

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= '0;
			for (int r = 0; r < `AREG_NUM; r++) begin
				arch_rf[r] <= '0;
			end
		end else begin
			out_valid <= ret_valid;
			// higher slot is younger and wins on equal dst
			for (int i = 0; i < `ROB_WIDTH; i++) begin
				if (ret_valid[i]) begin
					arch_rf[ret_dst[i]] <= ret_data[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			out_dst[i] <= ret_dst[i];
			out_data[i] <= ret_data[i];
			out_pc[i] <= ret_pc[i];
			clr_tag[i] <= ret_tag[i];
		end
	end

	// alias clear follows the retirement report
	assign clr_valid = out_valid;

	always_comb begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			arch_rdata[i] = arch_rf[arch_raddr[i]];
		end
	end

endmodule

/* rtl/rob_top.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top (
	input logic clk,
	input logic reset,
	input logic [`ROB_WIDTH-1:0] disp_valid,
	input rob_pkg::areg_t disp_dst [`ROB_WIDTH],
	input rob_pkg::areg_t disp_src [`ROB_WIDTH],
	input rob_pkg::pc_t disp_pc [`ROB_WIDTH],
	output logic stall,
	output rob_pkg::tag_t alloc_tag [`ROB_WIDTH],
	output rob_pkg::tag_t src_tag [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] src_pending,
	output rob_pkg::data_t src_data [`ROB_WIDTH],
	input logic [`ROB_WIDTH-1:0] wb_valid,
	input rob_pkg::tag_t wb_tag [`ROB_WIDTH],
	input rob_pkg::data_t wb_data [`ROB_WIDTH],
	output logic [`ROB_WIDTH-1:0] out_valid,
	output rob_pkg::areg_t out_dst [`ROB_WIDTH],
	output rob_pkg::data_t out_data [`ROB_WIDTH],
	output rob_pkg::pc_t out_pc [`ROB_WIDTH]
);

	// rename to rob
	logic [`ROB_WIDTH-1:0] alloc_valid;
	rob_pkg::areg_t alloc_dst [`ROB_WIDTH];
	rob_pkg::pc_t alloc_pc [`ROB_WIDTH];
	rob_pkg::tag_t look_tag [`ROB_WIDTH];
	logic [`ROB_WIDTH-1:0] look_done;
	rob_pkg::data_t look_data [`ROB_WIDTH];

	// rob to retire
	logic [`ROB_WIDTH-1:0] ret_valid;
	rob_pkg::tag_t ret_tag [`ROB_WIDTH];
	rob_pkg::areg_t ret_dst [`ROB_WIDTH];
	rob_pkg::data_t ret_data [`ROB_WIDTH];
	rob_pkg::pc_t ret_pc [`ROB_WIDTH];

	// retire back to rename
	logic [`ROB_WIDTH-1:0] clr_valid;
	rob_pkg::tag_t clr_tag [`ROB_WIDTH];
	rob_pkg::areg_t arch_raddr [`ROB_WIDTH];
	rob_pkg::data_t arch_rdata [`ROB_WIDTH];

	rename_stage i_rename_stage (.*);

	rob i_rob (.*);

	retire_stage i_retire_stage (.*);

endmodule

/* dv/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb;

	localparam int CLK_PERIOD = 20;
	localparam int LINE_CYCLES = 100;

	logic clk;
	logic reset;
	logic [`ROB_WIDTH-1:0] disp_valid;
	rob_pkg::areg_t disp_dst [`ROB_WIDTH];
	rob_pkg::areg_t disp_src [`ROB_WIDTH];
	rob_pkg::pc_t disp_pc [`ROB_WIDTH];
	logic stall;
	rob_pkg::tag_t alloc_tag [`ROB_WIDTH];
	rob_pkg::tag_t src_tag [`ROB_WIDTH];
	logic [`ROB_WIDTH-1:0] src_pending;
	rob_pkg::data_t src_data [`ROB_WIDTH];
	logic [`ROB_WIDTH-1:0] wb_valid;
	rob_pkg::tag_t wb_tag [`ROB_WIDTH];
	rob_pkg::data_t wb_data [`ROB_WIDTH];
	logic [`ROB_WIDTH-1:0] out_valid;
	rob_pkg::areg_t out_dst [`ROB_WIDTH];
	rob_pkg::data_t out_data [`ROB_WIDTH];
	rob_pkg::pc_t out_pc [`ROB_WIDTH];

	int fd;
	int line_count;
	// group stays on the inputs while stall is high
	logic hold;
	logic [31:0] f_stall;
	logic [31:0] f_v [`ROB_WIDTH];
	logic [31:0] f_dst [`ROB_WIDTH];
	logic [31:0] f_src [`ROB_WIDTH];
	logic [31:0] f_pc [`ROB_WIDTH];
	logic [31:0] f_tag [`ROB_WIDTH];
	logic [31:0] f_stag [`ROB_WIDTH];
	logic [31:0] f_spend [`ROB_WIDTH];
	logic [31:0] f_data [`ROB_WIDTH];

	// expected retirements, oldest first
	logic [31:0] exp_dst_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] exp_pc_q [$];

	rob_top i_rob_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, expected));
		end
	endtask

	task automatic dispatch_group();
		int r;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			r = $fscanf(fd, "%h %h %h %h", f_v[i], f_dst[i], f_src[i], f_pc[i]);
		end
		r = $fscanf(fd, "%h", f_stall);
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			r = $fscanf(fd, "%h %h %h %h", f_tag[i], f_stag[i], f_spend[i], f_data[i]);
		end
		@(posedge clk);
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			disp_valid[i] <= f_v[i][0];
			disp_dst[i] <= rob_pkg::areg_t'(f_dst[i]);
			disp_src[i] <= rob_pkg::areg_t'(f_src[i]);
			disp_pc[i] <= rob_pkg::pc_t'(f_pc[i]);
		end
		wb_valid <= '0;
		hold = f_stall[0];
		@(negedge clk);
		compare_value("stall", 32'(stall), f_stall);
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			if (!f_stall[0] && f_v[i][0]) begin
				compare_value($sformatf("alloc_tag[%0d]", i), 32'(alloc_tag[i]), f_tag[i]);
				compare_value($sformatf("src_pending[%0d]", i), 32'(src_pending[i]), f_spend[i]);
				// data is defined only once the source is resolved
				if (f_spend[i][0]) begin
					compare_value($sformatf("src_tag[%0d]", i), 32'(src_tag[i]), f_stag[i]);
				end else begin
					compare_value($sformatf("src_data[%0d]", i), src_data[i], f_data[i]);
				end
			end
		end
	endtask

	task automatic apply_writeback();
		int r;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			r = $fscanf(fd, "%h %h %h", f_v[i], f_tag[i], f_data[i]);
		end
		@(posedge clk);
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			wb_valid[i] <= f_v[i][0];
			wb_tag[i] <= rob_pkg::tag_t'(f_tag[i]);
			wb_data[i] <= f_data[i];
		end
		if (!hold) begin
			disp_valid <= '0;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			wb_valid <= '0;
			if (!hold) begin
				disp_valid <= '0;
			end
		end
	endtask

	// every out_valid slot must match the next expected retirement
	always @(negedge clk) begin
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			if (!reset && out_valid[i]) begin
				if (exp_dst_q.size() == 0) begin
					abort_run($sformatf("Unexpected retirement on slot %0d at %0t", i, $time));
				end else begin
					compare_value($sformatf("out_dst[%0d]", i), 32'(out_dst[i]),
						exp_dst_q.pop_front());
					compare_value($sformatf("out_data[%0d]", i), out_data[i],
						exp_data_q.pop_front());
					compare_value($sformatf("out_pc[%0d]", i), 32'(out_pc[i]),
						exp_pc_q.pop_front());
				end
			end
		end
	end

	initial begin
		wait (line_count > 0);
		#(line_count * LINE_CYCLES * CLK_PERIOD);
		abort_run("Timeout, the case file did not finish in time");
	end

	initial begin
		string line;
		logic [7:0] op;
		int r;
		int n;
		logic [31:0] e_dst;
		logic [31:0] e_data;
		logic [31:0] e_pc;
		reset <= 1'b1;
		disp_valid <= '0;
		wb_valid <= '0;
		for (int i = 0; i < `ROB_WIDTH; i++) begin
			disp_dst[i] <= '0;
			disp_src[i] <= '0;
			disp_pc[i] <= '0;
			wb_tag[i] <= '0;
			wb_data[i] <= '0;
		end
		hold = 1'b0;
		fd = $fopen("dv/rob_cases.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the case file dv/rob_cases.txt");
		end
		while ($fgets(line, fd) != 0) begin
			line_count++;
		end
		$fclose(fd);
		fd = $fopen("dv/rob_cases.txt", "r");
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		while ($fscanf(fd, " %c", op) == 1) begin
			case (op)
				"D": dispatch_group();
				"W": apply_writeback();
				"I": begin
					r = $fscanf(fd, "%d", n);
					idle_cycles(n);
				end
				"R": begin
					r = $fscanf(fd, "%h %h %h", e_dst, e_data, e_pc);
					exp_dst_q.push_back(e_dst);
					exp_data_q.push_back(e_data);
					exp_pc_q.push_back(e_pc);
				end
				"#": r = $fgets(line, fd);
				default: abort_run($sformatf("Unknown line type %c in the case file", op));
			endcase
		end
		$fclose(fd);
		repeat (2) @(posedge clk);
		if (exp_dst_q.size() != 0) begin
			abort_run("Expected retirements are missing at the end of the run");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* dv/rob_cases.txt */
# D: v dst src pc for slot 0 and 1, stall, then tag src_tag pending src_data per slot
# W: v tag data per slot. R: dst data pc. I: idle cycles in decimal. Other fields hex
D 1 1 2 0100 1 2 1 0104 0 0 0 0 00000000 1 0 1 00000000
D 1 3 1 0108 1 1 3 010c 0 2 0 1 00000000 3 2 1 00000000
R 1 0000aaaa 0100
R 2 0000bbbb 0104
R 3 0000cccc 0108
R 1 0000dddd 010c
W 1 2 0000cccc 1 1 0000bbbb
D 1 4 3 0110 1 5 2 0114 0 4 0 0 0000cccc 5 0 0 0000bbbb
W 1 0 0000aaaa 1 3 0000dddd
I 3
D 1 6 1 0118 1 7 2 011c 0 6 0 0 0000dddd 7 0 0 0000bbbb
R 4 00000044 0110
R 5 00000055 0114
R 6 00000066 0118
R 7 00000077 011c
W 1 4 00000044 1 5 00000055
W 1 6 00000066 1 7 00000077
I 4
D 1 1 0 0200 1 2 0 0204 0 8 0 0 00000000 9 0 0 00000000
D 1 1 0 0208 1 2 0 020c 0 a 0 0 00000000 b 0 0 00000000
D 1 1 0 0210 1 2 0 0214 0 c 0 0 00000000 d 0 0 00000000
D 1 1 0 0218 1 2 0 021c 0 e 0 0 00000000 f 0 0 00000000
D 1 1 0 0220 1 2 0 0224 0 0 0 0 00000000 1 0 0 00000000
D 1 1 0 0228 1 2 0 022c 0 2 0 0 00000000 3 0 0 00000000
D 1 1 0 0230 1 2 0 0234 0 4 0 0 00000000 5 0 0 00000000
D 1 1 0 0238 1 2 0 023c 0 6 0 0 00000000 7 0 0 00000000
D 1 3 1 0240 1 4 3 0244 1 0 0 0 00000000 0 0 0 00000000
R 1 00000108 0200
R 2 00000109 0204
W 1 8 00000108 1 9 00000109
I 1
D 1 3 1 0240 1 4 3 0244 0 8 6 1 00000000 9 8 1 00000000
I 2

/* list.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/bank_ram.sv
rtl/rename_stage.sv
rtl/rob.sv
rtl/retire_stage.sv
rtl/rob_top.sv
dv/rob_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module rob_tb -o rob_sim

out=$(./obj_dir/rob_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
